// File: video_pkg.sv
package video_pkg;

	typedef enum logic [1:0] {
		mode_hmd  = 2'd0, // 1440x900
		mode_xga  = 2'd1, // 1024x768
		mode_fhd  = 2'd2, // 1920x1080
		mode_720p = 2'd3  // 1280x720
	} video_mode_e;

	typedef logic [11:0] count_t;
	typedef logic [7:0]  pixel_t;
	typedef logic [7:0]  clk_div_t; // Synthesizer M or D, minus one

	typedef struct packed {
		count_t   hpixels;
		count_t   hfp;
		count_t   hsync_pw;
		count_t   hbp;
		count_t   vlines;
		count_t   vfp;
		count_t   vsync_pw;
		count_t   vbp;
		logic     sync_active_low;
		clk_div_t pclk_m;
		clk_div_t pclk_d;
	} mode_timing_t;

	////////////////////////////////////////////////////////////
	// Per-mode timing, indexed by video_mode_e
	////////////////////////////////////////////////////////////
	localparam mode_timing_t MODE_TABLE [4] = '{
		'{hpixels: 12'd1440, hfp: 12'd80, hsync_pw: 12'd152, hbp: 12'd232,
			vlines: 12'd900, vfp: 12'd1, vsync_pw: 12'd3, vbp: 12'd28,
			sync_active_low: 1'b1, pclk_m: 8'd180, pclk_d: 8'd84},   // 106.47 MHz
		'{hpixels: 12'd1024, hfp: 12'd24, hsync_pw: 12'd136, hbp: 12'd160,
			vlines: 12'd768, vfp: 12'd3, vsync_pw: 12'd6, vbp: 12'd29,
			sync_active_low: 1'b1, pclk_m: 8'd81, pclk_d: 8'd62},    // 65 MHz
		'{hpixels: 12'd1920, hfp: 12'd88, hsync_pw: 12'd44, hbp: 12'd148,
			vlines: 12'd1080, vfp: 12'd4, vsync_pw: 12'd5, vbp: 12'd36,
			sync_active_low: 1'b0, pclk_m: 8'd198, pclk_d: 8'd66},   // 148.5 MHz
		'{hpixels: 12'd1280, hfp: 12'd110, hsync_pw: 12'd40, hbp: 12'd220,
			vlines: 12'd720, vfp: 12'd5, vsync_pw: 12'd5, vbp: 12'd20,
			sync_active_low: 1'b0, pclk_m: 8'd247, pclk_d: 8'd166}   // 74.25 MHz
	};

	// Colour bars as {red, green, blue}
	localparam logic [23:0] BAR_COLORS [8] = '{
		24'hFFFFFF, // White
		24'hFFFF00, // Yellow
		24'h00FFFF, // Cyan
		24'h00FF00, // Green
		24'hFF00FF, // Magenta
		24'hFF0000, // Red
		24'h0000FF, // Blue
		24'h000000  // Black
	};

	function automatic count_t h_total(video_mode_e m);
		mode_timing_t t;
		t = MODE_TABLE[m];
		return t.hpixels + t.hfp + t.hsync_pw + t.hbp;
	endfunction

	function automatic count_t v_total(video_mode_e m);
		mode_timing_t t;
		t = MODE_TABLE[m];
		return t.vlines + t.vfp + t.vsync_pw + t.vbp;
	endfunction

endpackage

// File: mode_ctrl.sv
module mode_ctrl import video_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  logic        clk50m_bufg,
	input  logic        rst,
	input  logic [1:0]  mode_sw,
	output video_mode_e mode,
	output logic        mode_change,
	output clk_div_t    pclk_m,
	output clk_div_t    pclk_d
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	logic [1:0]       sw_meta;
	logic [1:0]       sw_sync;
	video_mode_e      sw_last;    // Last synchronized switch value
	logic [CNT_W-1:0] stable_cnt;
	logic             commit;

	////////////////////////////////////////////////////////////
	// Two-flop synchronizer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			sw_meta <= 2'b00;
			sw_sync <= 2'b00;
		end else begin
			sw_meta <= mode_sw;
			sw_sync <= sw_meta;
		end
	end

	// Stability counter, restarts on any switch movement
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			sw_last    <= mode_hmd;
			stable_cnt <= '0;
		end else if (sw_sync != sw_last) begin
			sw_last    <= video_mode_e'(sw_sync);
			stable_cnt <= '0;
		end else if (stable_cnt != CNT_LAST) begin
			stable_cnt <= stable_cnt + 1'b1; // Saturates at CNT_LAST
		end
	end

	assign commit = (stable_cnt == CNT_LAST) && (sw_last != mode);

	////////////////////////////////////////////////////////////
	// Committed mode and synthesizer values
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			mode        <= mode_hmd;
			pclk_m      <= MODE_TABLE[mode_hmd].pclk_m;
			pclk_d      <= MODE_TABLE[mode_hmd].pclk_d;
			mode_change <= 1'b0;
		end else begin
			mode_change <= commit; // One-cycle pulse with the new mode
			if (commit) begin
				mode   <= sw_last;
				pclk_m <= MODE_TABLE[sw_last].pclk_m;
				pclk_d <= MODE_TABLE[sw_last].pclk_d;
			end
		end
	end

	a_change_single: assert property (@(posedge clk50m_bufg) disable iff (rst)
		mode_change |=> !mode_change);

endmodule

// File: video_timing.sv
module video_timing import video_pkg::*; (
	input  logic        clk50m_bufg,
	input  logic        rst,
	input  video_mode_e mode,
	input  logic        mode_change,
	output count_t      hcount,
	output logic        hblnk,
	output logic        vblnk,
	output logic        hsync_raw,
	output logic        vsync_raw
);

	mode_timing_t tm;
	count_t       htotal;
	count_t       vtotal;
	count_t       hs_start;
	count_t       hs_end;
	count_t       vs_start;
	count_t       vs_end;
	count_t       vcount;
	count_t       h_next;
	count_t       v_next;

	assign tm       = MODE_TABLE[mode];
	assign htotal   = h_total(mode);
	assign vtotal   = v_total(mode);
	assign hs_start = tm.hpixels + tm.hfp;       // First hsync pixel
	assign hs_end   = hs_start + tm.hsync_pw;    // First pixel after hsync
	assign vs_start = tm.vlines + tm.vfp;
	assign vs_end   = vs_start + tm.vsync_pw;

	////////////////////////////////////////////////////////////
	// Next counter values
	////////////////////////////////////////////////////////////
	always_comb begin
		h_next = hcount + 12'd1;
		v_next = vcount;
		if (mode_change) begin
			h_next = '0; // Restart the frame in the new mode
			v_next = '0;
		end else if (hcount == htotal - 12'd1) begin
			h_next = '0;
			if (vcount == vtotal - 12'd1) begin
				v_next = '0;
			end else begin
				v_next = vcount + 12'd1;
			end
		end
	end

	// Decode from the next counts so flags line up with hcount
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			hcount    <= '0;
			vcount    <= '0;
			hblnk     <= 1'b0;
			vblnk     <= 1'b0;
			hsync_raw <= 1'b0;
			vsync_raw <= 1'b0;
		end else begin
			hcount    <= h_next;
			vcount    <= v_next;
			hblnk     <= (h_next >= tm.hpixels);
			vblnk     <= (v_next >= tm.vlines);
			hsync_raw <= (h_next >= hs_start) && (h_next < hs_end);
			vsync_raw <= (v_next >= vs_start) && (v_next < vs_end);
		end
	end

	// Old count may still be out of range in the mode_change cycle
	a_hcount_range: assert property (@(posedge clk50m_bufg) disable iff (rst)
		!mode_change |-> (hcount < htotal));

endmodule

// File: color_bar.sv
module color_bar import video_pkg::*; (
	input  logic        clk50m_bufg,
	input  logic        rst,
	input  video_mode_e mode,
	input  count_t      hcount,
	output pixel_t      red,
	output pixel_t      green,
	output pixel_t      blue
);

	count_t     bar_w;     // One eighth of the active width
	logic [2:0] bar_idx_d;
	logic [2:0] bar_idx_q;

	assign bar_w = MODE_TABLE[mode].hpixels >> 3;

	////////////////////////////////////////////////////////////
	// Stage 1: bar index by boundary compare
	////////////////////////////////////////////////////////////
	always_comb begin
		bar_idx_d = 3'd0;
		for (int k = 1; k < 8; k++) begin
			if (hcount >= count_t'(bar_w * k)) begin
				bar_idx_d = 3'(k);
			end
		end
		if (hcount >= MODE_TABLE[mode].hpixels) begin
			bar_idx_d = 3'd7; // Black in blanking
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			bar_idx_q <= 3'd7;
		end else begin
			bar_idx_q <= bar_idx_d;
		end
	end

	// Stage 2: colour lookup
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else begin
			{red, green, blue} <= BAR_COLORS[bar_idx_q];
		end
	end

endmodule

// File: video_out.sv
module video_out import video_pkg::*; (
	input  logic        clk50m_bufg,
	input  logic        rst,
	input  video_mode_e mode,
	input  logic        hblnk,
	input  logic        vblnk,
	input  logic        hsync_raw,
	input  logic        vsync_raw,
	input  pixel_t      red_in,
	input  pixel_t      green_in,
	input  pixel_t      blue_in,
	output logic        hsync,
	output logic        vsync,
	output logic        de,
	output pixel_t      red,
	output pixel_t      green,
	output pixel_t      blue
);

	localparam logic RST_POL = MODE_TABLE[mode_hmd].sync_active_low;

	logic pol;
	logic hsync_q1;
	logic vsync_q1;
	logic de_q1;

	assign pol = MODE_TABLE[mode].sync_active_low;

	////////////////////////////////////////////////////////////
	// Two-stage alignment with the colour pipeline
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			hsync_q1 <= RST_POL; // Idle level of HMD
			vsync_q1 <= RST_POL;
			de_q1    <= 1'b0;
			hsync    <= RST_POL;
			vsync    <= RST_POL;
			de       <= 1'b0;
		end else begin
			hsync_q1 <= hsync_raw ^ pol;
			vsync_q1 <= vsync_raw ^ pol;
			de_q1    <= !(hblnk || vblnk);
			hsync    <= hsync_q1;
			vsync    <= vsync_q1;
			de       <= de_q1;
		end
	end

	assign red   = de ? red_in   : '0;
	assign green = de ? green_in : '0;
	assign blue  = de ? blue_in  : '0;

	a_rgb_blank: assert property (@(posedge clk50m_bufg) disable iff (rst)
		!de |-> (red == '0 && green == '0 && blue == '0));

endmodule

// File: video_top.sv
module video_top import video_pkg::*; #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  logic       clk50m_bufg,
	input  logic       rst,
	input  logic [1:0] mode_sw,
	output logic       hsync,
	output logic       vsync,
	output logic       de,
	output pixel_t     red,
	output pixel_t     green,
	output pixel_t     blue,
	output clk_div_t   pclk_m,
	output clk_div_t   pclk_d
);

	video_mode_e mode;
	logic        mode_change;
	count_t      hcount;
	logic        hblnk;
	logic        vblnk;
	logic        hsync_raw;
	logic        vsync_raw;
	pixel_t      bar_red;
	pixel_t      bar_green;
	pixel_t      bar_blue;

	mode_ctrl #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_mode_ctrl (
		.clk50m_bufg (clk50m_bufg),
		.rst         (rst),
		.mode_sw     (mode_sw),
		.mode        (mode),
		.mode_change (mode_change),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d)
	);

	video_timing u_video_timing (
		.clk50m_bufg (clk50m_bufg),
		.rst         (rst),
		.mode        (mode),
		.mode_change (mode_change),
		.hcount      (hcount),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw)
	);

	color_bar u_color_bar (
		.clk50m_bufg (clk50m_bufg),
		.rst         (rst),
		.mode        (mode),
		.hcount      (hcount),
		.red         (bar_red),
		.green       (bar_green),
		.blue        (bar_blue)
	);

	video_out u_video_out (
		.clk50m_bufg (clk50m_bufg),
		.rst         (rst),
		.mode        (mode),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw),
		.red_in      (bar_red),
		.green_in    (bar_green),
		.blue_in     (bar_blue),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue)
	);

endmodule

// File: tb_checker.sv
module tb_checker import video_pkg::*; (
	input  logic         clk50m_bufg,
	input  logic         hsync,
	input  logic         vsync,
	input  logic         de,
	input  pixel_t       red,
	input  pixel_t       green,
	input  pixel_t       blue,
	input  clk_div_t     pclk_m,
	input  clk_div_t     pclk_d,
	input  video_mode_e  exp_mode,
	input  logic [127:0] test_name,
	input  int           num_lines,
	input  logic         glitch_win,
	input  logic         check_req,
	output logic         check_done,
	output int           errors,
	output int           lines_seen
);

	timeunit 1ns;
	timeprecision 1ps;

	task automatic check_value(input string what, input int exp, input int act);
		if (exp != act) begin
			errors++;
			$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Line measurement, sampled on the falling edge
	////////////////////////////////////////////////////////////
	task automatic measure_lines();
		mode_timing_t t;
		int           htotal;
		logic         act;
		logic         prev;
		int           period;
		int           width;
		int           run;
		int           gap;
		int           bar;
		logic         saw_de;
		logic [23:0]  exp_rgb;
		t      = MODE_TABLE[exp_mode];
		htotal = int'(t.hpixels) + int'(t.hfp) + int'(t.hsync_pw) + int'(t.hbp);
		act    = !t.sync_active_low; // Active sync level
		check_value("pclk_m", int'(t.pclk_m), int'(pclk_m));
		check_value("pclk_d", int'(t.pclk_d), int'(pclk_d));
		repeat (4) @(negedge clk50m_bufg); // Old mode may still be in the output pipeline
		prev = hsync;
		@(negedge clk50m_bufg);
		while (!(hsync == act && prev != act)) begin
			prev = hsync;
			@(negedge clk50m_bufg);
		end
		for (int n = 0; n < num_lines; n++) begin
			period = 0;
			width  = 0;
			run    = 0;
			gap    = 0;
			saw_de = 1'b0;
			do begin
				period++;
				if (hsync == act) begin
					width++;
				end
				check_value("vsync idle", int'(t.sync_active_low), int'(vsync));
				if (de) begin
					bar = (run * 8) / int'(t.hpixels);
					if (bar > 7) begin
						bar = 7;
					end
					exp_rgb = BAR_COLORS[3'(bar)];
					run++;
				end else begin
					exp_rgb = 24'h000000; // Blanked
					if (run != 0) begin
						check_value("de run", int'(t.hpixels), run);
						run    = 0;
						saw_de = 1'b1;
					end
					if (saw_de) begin
						gap++; // Front porch
					end
				end
				if ({red, green, blue} != exp_rgb) begin
					errors++;
					$display("[FAIL] %s pixel %0d: expected %06h, actual %06h", test_name,
						run - 1, exp_rgb, {red, green, blue});
				end
				prev = hsync;
				@(negedge clk50m_bufg);
			end while (!(hsync == act && prev != act));
			check_value("hsync period", htotal, period);
			check_value("hsync width", int'(t.hsync_pw), width);
			if (run != 0) begin
				errors++;
				$display("%s: de was still high at the hsync edge", test_name);
			end else if (!saw_de) begin
				errors++;
				$display("%s: a measured line had no active pixels", test_name);
			end else begin
				check_value("front porch", int'(t.hfp), gap);
			end
			lines_seen++;
		end
	endtask

	// Synthesizer values stay on the committed mode through a short glitch
	always @(negedge clk50m_bufg) begin
		if (glitch_win) begin
			check_value("pclk_m hold", int'(MODE_TABLE[exp_mode].pclk_m), int'(pclk_m));
			check_value("pclk_d hold", int'(MODE_TABLE[exp_mode].pclk_d), int'(pclk_d));
		end
	end

	// Request and done handshake with the stimulus loop
	initial begin
		check_done = 1'b0;
		errors     = 0;
		lines_seen = 0;
		forever begin
			wait (check_req);
			measure_lines();
			check_done = 1'b1;
			wait (!check_req);
			check_done = 1'b0;
		end
	end

endmodule

// File: tb_video_top.sv
module tb_video_top import video_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEBOUNCE_CYCLES = 16;
	localparam int NUM_TESTS       = 5;

	typedef struct packed {
		logic [127:0] name;
		video_mode_e  mode;        // Selected and expected mode
		logic         glitch;
		video_mode_e  glitch_mode; // Short pulse target before mode
		logic [3:0]   lines;
	} test_t;

	localparam test_t TESTS [NUM_TESTS] = '{
		'{"hmd_reset",  mode_hmd,  1'b0, mode_hmd,  4'd3},
		'{"mode_720p",  mode_720p, 1'b0, mode_720p, 4'd3},
		'{"glitch_fhd", mode_720p, 1'b1, mode_fhd,  4'd3},
		'{"mode_fhd",   mode_fhd,  1'b0, mode_fhd,  4'd3},
		'{"mode_xga",   mode_xga,  1'b0, mode_xga,  4'd3}
	};

	logic         clk50m_bufg;
	logic         rst;
	logic [1:0]   mode_sw;
	logic         hsync;
	logic         vsync;
	logic         de;
	pixel_t       red;
	pixel_t       green;
	pixel_t       blue;
	clk_div_t     pclk_m;
	clk_div_t     pclk_d;
	video_mode_e  exp_mode;
	logic [127:0] test_name;
	int           num_lines;
	logic         glitch_win;
	logic         check_req;
	logic         check_done;
	int           errors;
	int           lines_seen;

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz
	end

	////////////////////////////////////////////////////////////
	// Watchdog, four lines plus slack per test
	////////////////////////////////////////////////////////////
	initial begin
		longint       limit;
		mode_timing_t t;
		limit = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			t = MODE_TABLE[TESTS[i].mode];
			limit += 4 * (longint'(t.hpixels) + t.hfp + t.hsync_pw + t.hbp) + 100;
		end
		#(limit * 20);
		$display("Watchdog expired after %0d ns, the run timed out", limit * 20);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Stimulus loop
	////////////////////////////////////////////////////////////
	initial begin
		int glitch_len;
		void'($urandom(22927));
		rst        <= 1'b1;
		mode_sw    <= 2'd0;
		exp_mode   <= mode_hmd;
		test_name  <= '0;
		num_lines  <= 0;
		glitch_win <= 1'b0;
		check_req  <= 1'b0;
		repeat (5) @(posedge clk50m_bufg);
		rst <= 1'b0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			@(posedge clk50m_bufg);
			test_name <= TESTS[i].name;
			if (TESTS[i].glitch) begin
				glitch_len = 1 + int'($urandom % 15); // Always below the debounce time
				$display("Glitch of %0d cycles toward mode %0d", glitch_len,
					TESTS[i].glitch_mode);
				exp_mode   <= TESTS[i].mode; // Committed mode has to hold
				glitch_win <= 1'b1;
				mode_sw    <= TESTS[i].glitch_mode;
				repeat (glitch_len) @(posedge clk50m_bufg);
			end
			mode_sw <= TESTS[i].mode;
			repeat (DEBOUNCE_CYCLES + 4) @(posedge clk50m_bufg); // Worst-case commit
			glitch_win <= 1'b0;
			exp_mode   <= TESTS[i].mode;
			num_lines  <= int'(TESTS[i].lines);
			check_req  <= 1'b1;
			do begin
				@(posedge clk50m_bufg);
			end while (!check_done);
			check_req <= 1'b0;
			do begin
				@(posedge clk50m_bufg);
			end while (check_done);
		end
		$display("Summary: %0d lines checked, %0d errors", lines_seen, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	video_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) DUT (
		.clk50m_bufg (clk50m_bufg),
		.rst         (rst),
		.mode_sw     (mode_sw),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d)
	);

	tb_checker chk (
		.clk50m_bufg (clk50m_bufg),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.pclk_m      (pclk_m),
		.pclk_d      (pclk_d),
		.exp_mode    (exp_mode),
		.test_name   (test_name),
		.num_lines   (num_lines),
		.glitch_win  (glitch_win),
		.check_req   (check_req),
		.check_done  (check_done),
		.errors      (errors),
		.lines_seen  (lines_seen)
	);

endmodule

// File: video_top.f
video_pkg.sv
mode_ctrl.sv
video_timing.sv
color_bar.sv
video_out.sv
video_top.sv
tb_checker.sv
tb_video_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_video_top
FILELIST  := video_top.f
LOG       := sim.log
PASS_MSG  := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
